/* logic/f2c_pkg.sv */
package f2c_pkg;

    // Ring index width, so a ring holds at most 1024 slots
    localparam int RB_AWIDTH = 10;

    // One flit per ring slot
    localparam int FLIT_BYTES = 8;

    typedef struct packed {
        logic [63:0] data;
        logic        sop;
        logic        eop;
    } flit_t;

    // Host ring state as seen at packet arrival
    typedef struct packed {
        logic [31:0]          kmem_addr;
        logic [RB_AWIDTH-1:0] head;
        logic [RB_AWIDTH-1:0] tail;
    } queue_state_t;

    typedef struct packed {
        queue_state_t pkt_q;
        queue_state_t dsc_q;
        logic [7:0]   size;
        logic [7:0]   queue_id;
        logic         needs_dsc;
    } pkt_meta_t;

    // Descriptor beat, one ring slot wide
    typedef struct packed {
        logic        signal;
        logic [15:0] tail;
        logic [7:0]  queue_id;
        logic [38:0] pad;
    } pkt_dsc_t;

endpackage

/* logic/dma_wr_if.sv */
`timescale 1ns/100ps

// One write beat from the DMA writer to the bus output stage
interface dma_wr_if;
    logic        write;
    logic [31:0] address;
    logic [63:0] writedata;
    logic [3:0]  burstcount;
    logic        waitrequest;

    modport producer (
        output write,
        output address,
        output writedata,
        output burstcount,
        input  waitrequest
    );

    modport consumer (
        input  write,
        input  address,
        input  writedata,
        input  burstcount,
        output waitrequest
    );
endinterface

/* logic/f2c_fifo.sv */
`timescale 1ns/100ps

module f2c_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  FIFO_DEPTH = 16
) (
    input  logic                        clk,
    input  logic                        rst,
    input  payload_t                    in_data,
    input  logic                        in_valid,
    output logic                        in_ready,
    output payload_t                    out_data,
    output logic                        out_valid,
    input  logic                        out_ready,
    output logic [$clog2(FIFO_DEPTH):0] occup
);

    localparam int AW = $clog2(FIFO_DEPTH);

    payload_t      mem [FIFO_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          push;
    logic          pop;

    assign in_ready  = (count != (AW+1)'(FIFO_DEPTH));
    assign out_valid = (count != '0);
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;
    assign occup     = count;

    // Head word comes straight from the storage registers
    assign out_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* logic/f2c_dma_writer.sv */
`timescale 1ns/100ps

module f2c_dma_writer #(
    parameter int MAX_BURST = 8
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         sw_reset,
    input  logic [f2c_pkg::RB_AWIDTH:0]  pkt_rb_size,
    input  logic [f2c_pkg::RB_AWIDTH:0]  dsc_rb_size,
    input  f2c_pkg::flit_t               flit,
    input  logic                         flit_valid,
    output logic                         flit_ready,
    input  f2c_pkg::pkt_meta_t           meta,
    input  logic                         meta_valid,
    output logic                         meta_ready,
    dma_wr_if.producer                   wr,
    output logic [31:0]                  cpu_pkt_buf_full_cnt,
    output logic [31:0]                  cpu_dsc_buf_full_cnt
);

    localparam int AW = f2c_pkg::RB_AWIDTH;

    typedef enum logic [1:0] {
        ST_START_TRANSFER,
        ST_COMPLETE_BURST,
        ST_START_BURST,
        ST_SEND_DSC
    } state_t;

    state_t             state;
    state_t             data_next;
    logic [AW:0]        pkt_rb_size_r;
    logic [AW-1:0]      pkt_rb_mask;
    logic [AW-1:0]      dsc_rb_mask;
    f2c_pkg::pkt_meta_t meta_r;
    logic               meta_valid_r;
    f2c_pkg::pkt_meta_t cur;
    f2c_pkg::pkt_meta_t src;
    f2c_pkg::pkt_meta_t cur_next;
    f2c_pkg::pkt_dsc_t  dsc;
    logic [3:0]         burst_left;
    logic [3:0]         left_after;
    logic [AW:0]        to_end;
    logic [AW:0]        len;
    logic [AW-1:0]      pkt_free;
    logic [AW-1:0]      dsc_free;
    logic               pkt_room;
    logic               dsc_room;
    logic               first_beat;
    logic               skip;
    logic               data_req;
    logic               data_go;
    logic               dsc_go;
    logic               meta_take;

    always_ff @(posedge clk) begin
        pkt_rb_size_r <= pkt_rb_size;
        pkt_rb_mask   <= AW'(pkt_rb_size - 1'b1);
        dsc_rb_mask   <= AW'(dsc_rb_size - 1'b1);
    end

    // Skid register on the metadata head
    always_ff @(posedge clk) begin
        if (rst) begin
            meta_valid_r <= 1'b0;
        end else if (meta_ready) begin
            meta_valid_r <= meta_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (meta_ready) begin
            meta_r <= meta;
        end
    end

    always_comb begin
        // New packets come from the skid register, later beats from cur
        src        = (state == ST_START_TRANSFER) ? meta_r : cur;
        first_beat = (state != ST_COMPLETE_BURST);
        skip       = (src.pkt_q.kmem_addr == '0) || (src.dsc_q.kmem_addr == '0);

        // One slot always stays free in each ring
        pkt_free = (meta_r.pkt_q.head - meta_r.pkt_q.tail - 1'b1) & pkt_rb_mask;
        dsc_free = (meta_r.dsc_q.head - meta_r.dsc_q.tail - 1'b1) & dsc_rb_mask;
        pkt_room = (pkt_free >= {{(AW-8){1'b0}}, meta_r.size});
        dsc_room = (dsc_free != '0);

        // Burst never runs past MAX_BURST, the packet end or the ring end
        to_end = pkt_rb_size_r - {1'b0, src.pkt_q.tail};
        len    = (AW+1)'(MAX_BURST);
        if ({{(AW-7){1'b0}}, src.size} < len) begin
            len = {{(AW-7){1'b0}}, src.size};
        end
        if (to_end < len) begin
            len = to_end;
        end
        left_after = first_beat ? len[3:0] - 4'd1 : burst_left - 4'd1;

        cur_next            = src;
        cur_next.pkt_q.tail = (src.pkt_q.tail + 1'b1) & pkt_rb_mask;
        cur_next.size       = src.size - 8'd1;

        if (left_after != 4'd0) begin
            data_next = ST_COMPLETE_BURST;
        end else if (cur_next.size != 8'd0) begin
            data_next = ST_START_BURST;
        end else if (src.needs_dsc) begin
            data_next = ST_SEND_DSC;
        end else begin
            data_next = ST_START_TRANSFER;
        end

        dsc.signal   = 1'b1;
        dsc.tail     = {{(16-AW){1'b0}}, cur.pkt_q.tail};
        dsc.queue_id = cur.queue_id;
        dsc.pad      = '0;
    end

    // Unconfigured queues bypass the room check and drain without writes
    assign data_req = (state != ST_SEND_DSC) && flit_valid
                      && ((state != ST_START_TRANSFER)
                          || (meta_valid_r && (skip || (pkt_room && dsc_room))));
    assign data_go    = data_req && (skip || !wr.waitrequest);
    assign dsc_go     = (state == ST_SEND_DSC) && (skip || !wr.waitrequest);
    assign meta_take  = (state == ST_START_TRANSFER) && data_go;
    assign meta_ready = meta_take || !meta_valid_r;
    assign flit_ready = data_go;

    assign wr.write = !skip && (data_req || (state == ST_SEND_DSC));
    assign wr.address = (state == ST_SEND_DSC)
        ? src.dsc_q.kmem_addr + 32'(f2c_pkg::FLIT_BYTES) * 32'(src.dsc_q.tail)
        : src.pkt_q.kmem_addr + 32'(f2c_pkg::FLIT_BYTES) * 32'(src.pkt_q.tail);
    assign wr.writedata  = (state == ST_SEND_DSC) ? dsc : flit.data;
    assign wr.burstcount = (state == ST_SEND_DSC) ? 4'd1
                         : (first_beat ? len[3:0] : 4'd0);

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= ST_START_TRANSFER;
            burst_left <= '0;
        end else if (data_go) begin
            state      <= data_next;
            burst_left <= left_after;
        end else if (dsc_go) begin
            state <= ST_START_TRANSFER;
        end
    end

    always_ff @(posedge clk) begin
        if (data_go) begin
            cur <= cur_next;
        end
    end

    // Cycles where a waiting packet is held back by a full ring
    always_ff @(posedge clk) begin
        if (rst || sw_reset) begin
            cpu_pkt_buf_full_cnt <= '0;
            cpu_dsc_buf_full_cnt <= '0;
        end else if (state == ST_START_TRANSFER && meta_valid_r && !skip) begin
            if (!pkt_room) begin
                cpu_pkt_buf_full_cnt <= cpu_pkt_buf_full_cnt + 1'b1;
            end
            if (!dsc_room) begin
                cpu_dsc_buf_full_cnt <= cpu_dsc_buf_full_cnt + 1'b1;
            end
        end
    end

endmodule

/* logic/bas_output_stage.sv */
`timescale 1ns/100ps

module bas_output_stage (
    input  logic        clk,
    input  logic        rst,
    input  logic        sw_reset,
    dma_wr_if.consumer  wr,
    input  logic        bus_waitrequest,
    output logic        bus_write,
    output logic [31:0] bus_address,
    output logic [63:0] bus_writedata,
    output logic [3:0]  bus_burstcount,
    output logic [31:0] dma_queue_full_cnt
);

    // Writer sees the bus back-pressure directly
    assign wr.waitrequest = bus_waitrequest;

    always_ff @(posedge clk) begin
        if (rst) begin
            bus_write <= 1'b0;
        end else if (!bus_waitrequest) begin
            bus_write <= wr.write;
        end
    end

    // Beat fields move only when the bus accepts
    always_ff @(posedge clk) begin
        if (!bus_waitrequest) begin
            bus_address    <= wr.address;
            bus_writedata  <= wr.writedata;
            bus_burstcount <= wr.burstcount;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || sw_reset) begin
            dma_queue_full_cnt <= '0;
        end else if (bus_write && bus_waitrequest) begin
            dma_queue_full_cnt <= dma_queue_full_cnt + 1'b1;
        end
    end

endmodule

/* logic/fpga_to_cpu.sv */
`timescale 1ns/100ps

module fpga_to_cpu #(
    parameter int FIFO_DEPTH = 16,
    parameter int MAX_BURST  = 8
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         sw_reset,

    // Packet flits in
    input  f2c_pkg::flit_t               pkt_in_data,
    input  logic                         pkt_in_valid,
    output logic                         pkt_in_ready,
    output logic [$clog2(FIFO_DEPTH):0]  pkt_buf_occup,

    // Per-packet metadata in
    input  f2c_pkg::pkt_meta_t           meta_in_data,
    input  logic                         meta_in_valid,
    output logic                         meta_in_ready,
    output logic [$clog2(FIFO_DEPTH):0]  metadata_buf_occup,

    input  logic [f2c_pkg::RB_AWIDTH:0]  pkt_rb_size,
    input  logic [f2c_pkg::RB_AWIDTH:0]  dsc_rb_size,

    // Avalon-style write bus
    input  logic                         bus_waitrequest,
    output logic                         bus_write,
    output logic [31:0]                  bus_address,
    output logic [63:0]                  bus_writedata,
    output logic [3:0]                   bus_burstcount,

    output logic [31:0]                  dma_queue_full_cnt,
    output logic [31:0]                  cpu_pkt_buf_full_cnt,
    output logic [31:0]                  cpu_dsc_buf_full_cnt
);

    f2c_pkg::flit_t     pkt_buf_out_data;
    logic               pkt_buf_out_valid;
    logic               pkt_buf_out_ready;
    f2c_pkg::pkt_meta_t metadata_buf_out_data;
    logic               metadata_buf_out_valid;
    logic               metadata_buf_out_ready;

    dma_wr_if wr_if ();

    f2c_fifo #(
        .payload_t  (f2c_pkg::flit_t),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) pkt_buf (
        .clk       (clk),
        .rst       (rst),
        .in_data   (pkt_in_data),
        .in_valid  (pkt_in_valid),
        .in_ready  (pkt_in_ready),
        .out_data  (pkt_buf_out_data),
        .out_valid (pkt_buf_out_valid),
        .out_ready (pkt_buf_out_ready),
        .occup     (pkt_buf_occup)
    );

    f2c_fifo #(
        .payload_t  (f2c_pkg::pkt_meta_t),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) metadata_buf (
        .clk       (clk),
        .rst       (rst),
        .in_data   (meta_in_data),
        .in_valid  (meta_in_valid),
        .in_ready  (meta_in_ready),
        .out_data  (metadata_buf_out_data),
        .out_valid (metadata_buf_out_valid),
        .out_ready (metadata_buf_out_ready),
        .occup     (metadata_buf_occup)
    );

    f2c_dma_writer #(
        .MAX_BURST (MAX_BURST)
    ) dma_writer (
        .clk                  (clk),
        .rst                  (rst),
        .sw_reset             (sw_reset),
        .pkt_rb_size          (pkt_rb_size),
        .dsc_rb_size          (dsc_rb_size),
        .flit                 (pkt_buf_out_data),
        .flit_valid           (pkt_buf_out_valid),
        .flit_ready           (pkt_buf_out_ready),
        .meta                 (metadata_buf_out_data),
        .meta_valid           (metadata_buf_out_valid),
        .meta_ready           (metadata_buf_out_ready),
        .wr                   (wr_if.producer),
        .cpu_pkt_buf_full_cnt (cpu_pkt_buf_full_cnt),
        .cpu_dsc_buf_full_cnt (cpu_dsc_buf_full_cnt)
    );

    bas_output_stage out_stage (
        .clk                (clk),
        .rst                (rst),
        .sw_reset           (sw_reset),
        .wr                 (wr_if.consumer),
        .bus_waitrequest    (bus_waitrequest),
        .bus_write          (bus_write),
        .bus_address        (bus_address),
        .bus_writedata      (bus_writedata),
        .bus_burstcount     (bus_burstcount),
        .dma_queue_full_cnt (dma_queue_full_cnt)
    );

endmodule

/* testbench/f2c_asserts.sv */
`timescale 1ns/100ps

module f2c_asserts #(
    parameter int MAX_BURST = 8
) (
    input logic        clk,
    input logic        rst,
    input logic        bus_waitrequest,
    input logic        bus_write,
    input logic [31:0] bus_address,
    input logic [63:0] bus_writedata,
    input logic [3:0]  bus_burstcount
);

    // Beats still owed by the burst in progress, zero before a first beat
    logic [3:0] beats_left;

    always_ff @(posedge clk) begin
        if (rst) begin
            beats_left <= '0;
        end else if (bus_write && !bus_waitrequest) begin
            if (beats_left == 4'd0) begin
                beats_left <= bus_burstcount - 4'd1;
            end else begin
                beats_left <= beats_left - 4'd1;
            end
        end
    end

    held_beat_stable: assert property (@(posedge clk) disable iff (rst)
        bus_write && bus_waitrequest |=> bus_write && $stable(bus_address)
            && $stable(bus_writedata) && $stable(bus_burstcount))
        else $error("Bus beat changed while waitrequest was high");

    first_beat_burstcount: assert property (@(posedge clk) disable iff (rst)
        bus_write && (beats_left == 4'd0)
            |-> (bus_burstcount >= 4'd1) && (bus_burstcount <= 4'(MAX_BURST)))
        else $error("Burst count %0d out of range on a first beat", bus_burstcount);

    no_write_in_reset: assert property (@(posedge clk) rst |=> !bus_write)
        else $error("Bus write seen after a reset cycle");

endmodule

bind fpga_to_cpu f2c_asserts #(
    .MAX_BURST (MAX_BURST)
) bus_checks (
    .clk             (clk),
    .rst             (rst),
    .bus_waitrequest (bus_waitrequest),
    .bus_write       (bus_write),
    .bus_address     (bus_address),
    .bus_writedata   (bus_writedata),
    .bus_burstcount  (bus_burstcount)
);

/* testbench/tb_fpga_to_cpu.sv */
`timescale 1ns/100ps

module tb_fpga_to_cpu;

    localparam int FIFO_DEPTH     = 16;
    localparam int MAX_BURST      = 8;
    localparam int N_ROWS         = 7;
    localparam int TIMEOUT_CYCLES = 200 * N_ROWS;

    typedef struct packed {
        logic [7:0]  size;
        logic [10:0] pkt_rb;
        logic [10:0] dsc_rb;
        logic [31:0] pkt_base;
        logic [9:0]  pkt_head;
        logic [9:0]  pkt_tail;
        logic [31:0] dsc_base;
        logic [9:0]  dsc_head;
        logic [9:0]  dsc_tail;
        logic        needs_dsc;
        logic        rand_wait;
    } row_t;

    // size, pkt ring, dsc ring, pkt base/head/tail, dsc base/head/tail, needs_dsc, random wait
    localparam row_t ROWS [N_ROWS] = '{
        '{8'd1, 11'd1024, 11'd64, 32'h4000, 10'd5, 10'd5, 32'h8000, 10'd3, 10'd3, 1'b1, 1'b0},
        '{8'd20, 11'd1024, 11'd64, 32'h4000, 10'd0, 10'd0, 32'h8000, 10'd0, 10'd0, 1'b0, 1'b0},
        '{8'd10, 11'd64, 11'd16, 32'h4000, 10'd20, 10'd60, 32'h8000, 10'd2, 10'd15, 1'b1, 1'b0},
        '{8'd4, 11'd64, 11'd64, 32'h4000, 10'd12, 10'd10, 32'h8000, 10'd5, 10'd4, 1'b0, 1'b0},
        '{8'd12, 11'd1024, 11'd64, 32'h4000, 10'd100, 10'd100, 32'h8000, 10'd7, 10'd7, 1'b1, 1'b1},
        '{8'd5, 11'd1024, 11'd64, 32'h0, 10'd0, 10'd0, 32'h8000, 10'd0, 10'd0, 1'b1, 1'b0},
        '{8'd3, 11'd1024, 11'd64, 32'h4000, 10'd0, 10'd0, 32'h8000, 10'd0, 10'd0, 1'b0, 1'b0}
    };

    logic                        clk;
    logic                        rst;
    logic                        sw_reset;
    f2c_pkg::flit_t              pkt_in_data;
    logic                        pkt_in_valid;
    logic                        pkt_in_ready;
    logic [$clog2(FIFO_DEPTH):0] pkt_buf_occup;
    f2c_pkg::pkt_meta_t          meta_in_data;
    logic                        meta_in_valid;
    logic                        meta_in_ready;
    logic [$clog2(FIFO_DEPTH):0] metadata_buf_occup;
    logic [10:0]                 pkt_rb_size;
    logic [10:0]                 dsc_rb_size;
    logic                        bus_waitrequest = 1'b0;
    logic                        bus_write;
    logic [31:0]                 bus_address;
    logic [63:0]                 bus_writedata;
    logic [3:0]                  bus_burstcount;
    logic [31:0]                 dma_queue_full_cnt;
    logic [31:0]                 cpu_pkt_buf_full_cnt;
    logic [31:0]                 cpu_dsc_buf_full_cnt;

    int          seed;
    int          errors = 0;
    int          beats = 0;
    int          cycles = 0;
    logic        rand_wait = 1'b0;
    logic [63:0] pool [N_ROWS][32];
    logic [31:0] exp_addr [$];
    logic [63:0] exp_data [$];
    logic [3:0]  exp_bc [$];
    logic [31:0] mon_addr;
    logic [63:0] mon_data;
    logic [3:0]  mon_bc;

    fpga_to_cpu #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .MAX_BURST  (MAX_BURST)
    ) dut0 (
        .clk                  (clk),
        .rst                  (rst),
        .sw_reset             (sw_reset),
        .pkt_in_data          (pkt_in_data),
        .pkt_in_valid         (pkt_in_valid),
        .pkt_in_ready         (pkt_in_ready),
        .pkt_buf_occup        (pkt_buf_occup),
        .meta_in_data         (meta_in_data),
        .meta_in_valid        (meta_in_valid),
        .meta_in_ready        (meta_in_ready),
        .metadata_buf_occup   (metadata_buf_occup),
        .pkt_rb_size          (pkt_rb_size),
        .dsc_rb_size          (dsc_rb_size),
        .bus_waitrequest      (bus_waitrequest),
        .bus_write            (bus_write),
        .bus_address          (bus_address),
        .bus_writedata        (bus_writedata),
        .bus_burstcount       (bus_burstcount),
        .dma_queue_full_cnt   (dma_queue_full_cnt),
        .cpu_pkt_buf_full_cnt (cpu_pkt_buf_full_cnt),
        .cpu_dsc_buf_full_cnt (cpu_dsc_buf_full_cnt)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Run stopped after %0d cycles without finishing the tests", cycles);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // Random back-pressure, only in rows that ask for it
    always @(negedge clk) begin
        if (rand_wait) begin
            bus_waitrequest = 1'($random(seed));
        end else begin
            bus_waitrequest = 1'b0;
        end
    end

    // Every accepted beat is compared with the head of the expected queue
    always @(posedge clk) begin
        if (!rst && bus_write && !bus_waitrequest) begin
            assert (exp_data.size() != 0) else begin
                $display("Unexpected bus write at %0t to address %h", $time, bus_address);
                errors++;
            end
            if (exp_data.size() != 0) begin
                mon_addr = exp_addr.pop_front();
                mon_data = exp_data.pop_front();
                mon_bc   = exp_bc.pop_front();
                if (mon_bc != 4'd0) begin
                    assert (bus_address == mon_addr) else begin
                        $display("** Error at %0t: bus_address is %h, expected %h",
                                 $time, bus_address, mon_addr);
                        errors++;
                    end
                end
                assert (bus_burstcount == mon_bc) else begin
                    $display("** Error at %0t: bus_burstcount is %0d, expected %0d",
                             $time, bus_burstcount, mon_bc);
                    errors++;
                end
                assert (bus_writedata == mon_data) else begin
                    $display("** Error at %0t: bus_writedata is %h, expected %h",
                             $time, bus_writedata, mon_data);
                    errors++;
                end
                beats++;
            end
        end
    end

    task automatic apply_reset(input row_t t);
        rand_wait   <= 1'b0;
        rst         = 1'b1;
        pkt_rb_size = t.pkt_rb;
        dsc_rb_size = t.dsc_rb;
        repeat (2) @(negedge clk);
        rst = 1'b0;
    endtask

    // Reference model of the ring writes for one packet
    task automatic expect_row(input row_t t, input int r, output bit held);
        int pkt_free;
        int dsc_free;
        int left;
        int tail;
        int len;
        int i;
        held = 1'b0;
        if (t.pkt_base == 32'd0 || t.dsc_base == 32'd0) begin
            return;
        end
        pkt_free = (int'(t.pkt_head) - int'(t.pkt_tail) - 1 + int'(t.pkt_rb)) % int'(t.pkt_rb);
        dsc_free = (int'(t.dsc_head) - int'(t.dsc_tail) - 1 + int'(t.dsc_rb)) % int'(t.dsc_rb);
        if (pkt_free < int'(t.size) || dsc_free == 0) begin
            held = 1'b1;
            return;
        end
        left = int'(t.size);
        tail = int'(t.pkt_tail);
        i    = 0;
        while (left > 0) begin
            len = (left < MAX_BURST) ? left : MAX_BURST;
            if (int'(t.pkt_rb) - tail < len) begin
                len = int'(t.pkt_rb) - tail;
            end
            for (int k = 0; k < len; k++) begin
                exp_addr.push_back(t.pkt_base + 32'(f2c_pkg::FLIT_BYTES * tail));
                exp_data.push_back(pool[r][i]);
                exp_bc.push_back((k == 0) ? 4'(len) : 4'd0);
                i++;
            end
            tail = (tail + len) % int'(t.pkt_rb);
            left = left - len;
        end
        if (t.needs_dsc) begin
            exp_addr.push_back(t.dsc_base + 32'(f2c_pkg::FLIT_BYTES * int'(t.dsc_tail)));
            exp_data.push_back({1'b1, 16'(tail), 8'(r + 16), 39'd0});
            exp_bc.push_back(4'd1);
        end
    endtask

    task automatic send_meta(input row_t t, input int r);
        bit took;
        meta_in_data.pkt_q.kmem_addr = t.pkt_base;
        meta_in_data.pkt_q.head      = t.pkt_head;
        meta_in_data.pkt_q.tail      = t.pkt_tail;
        meta_in_data.dsc_q.kmem_addr = t.dsc_base;
        meta_in_data.dsc_q.head      = t.dsc_head;
        meta_in_data.dsc_q.tail      = t.dsc_tail;
        meta_in_data.size            = t.size;
        meta_in_data.queue_id        = 8'(r + 16);
        meta_in_data.needs_dsc       = t.needs_dsc;
        took = 1'b0;
        while (!took) begin
            meta_in_valid = 1'b1;
            took          = meta_in_ready;
            @(negedge clk);
        end
        meta_in_valid = 1'b0;
    endtask

    task automatic send_flits(input int r, input int n);
        int i;
        bit took;
        i = 0;
        while (i < n) begin
            pkt_in_data.data = pool[r][i];
            pkt_in_data.sop  = (i == 0);
            pkt_in_data.eop  = (i == n - 1);
            pkt_in_valid     = 1'b1;
            took             = pkt_in_ready;
            @(negedge clk);
            if (took) begin
                i++;
            end
        end
        pkt_in_valid = 1'b0;
    endtask

    task automatic check_count(input string name, input logic [31:0] value,
                               input logic [31:0] expected);
        assert (value == expected) else begin
            $display("** Error at %0t: %0s is %0d, expected %0d",
                     $time, name, value, expected);
            errors++;
        end
    endtask

    // Pulse sw_reset and check that every stall counter clears
    task automatic clear_counters();
        sw_reset = 1'b1;
        @(negedge clk);
        check_count("cpu_pkt_buf_full_cnt", cpu_pkt_buf_full_cnt, 32'd0);
        check_count("cpu_dsc_buf_full_cnt", cpu_dsc_buf_full_cnt, 32'd0);
        check_count("dma_queue_full_cnt", dma_queue_full_cnt, 32'd0);
        sw_reset = 1'b0;
    endtask

    initial begin
        bit held;
        int err_start;
        int beat_start;
        rst           = 1'b1;
        sw_reset      = 1'b0;
        pkt_in_data   = '0;
        pkt_in_valid  = 1'b0;
        meta_in_data  = '0;
        meta_in_valid = 1'b0;
        pkt_rb_size   = 11'd1024;
        dsc_rb_size   = 11'd64;
        seed          = 32'h6154_57da;
        for (int r = 0; r < N_ROWS; r++) begin
            for (int i = 0; i < 32; i++) begin
                pool[r][i] = {$random(seed), $random(seed)};
            end
        end

        for (int r = 0; r < N_ROWS; r++) begin
            err_start  = errors;
            beat_start = beats;
            apply_reset(ROWS[r]);
            expect_row(ROWS[r], r, held);
            rand_wait <= ROWS[r].rand_wait;
            send_meta(ROWS[r], r);
            send_flits(r, int'(ROWS[r].size));
            if (held) begin
                // Ring too full, so nothing may reach the bus
                repeat (100) @(negedge clk);
                // Held metadata waits in the skid register, its flits stay queued
                check_count("pkt_buf_occup", 32'(pkt_buf_occup), 32'(ROWS[r].size));
                check_count("metadata_buf_occup", 32'(metadata_buf_occup), 32'd0);
                assert (cpu_pkt_buf_full_cnt != 32'd0) else begin
                    $display("cpu_pkt_buf_full_cnt stayed at zero with the packet ring full");
                    errors++;
                end
                assert (cpu_dsc_buf_full_cnt != 32'd0) else begin
                    $display("cpu_dsc_buf_full_cnt stayed at zero with the descriptor ring full");
                    errors++;
                end
                clear_counters();
            end else begin
                while (exp_data.size() != 0 || pkt_buf_occup != '0
                       || metadata_buf_occup != '0) begin
                    @(negedge clk);
                end
                repeat (4) @(negedge clk);
            end
            if (ROWS[r].rand_wait) begin
                assert (dma_queue_full_cnt != 32'd0) else begin
                    $display("dma_queue_full_cnt stayed at zero under random waitrequest");
                    errors++;
                end
                clear_counters();
            end
            $display("Test %0d: %0d flits, %0d beats checked, %0d errors",
                     r, ROWS[r].size, beats - beat_start, errors - err_start);
        end

        $display("%0d tests, %0d beats checked, %0d errors", N_ROWS, beats, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* compile.f */
logic/f2c_pkg.sv
logic/dma_wr_if.sv
logic/f2c_fifo.sv
logic/f2c_dma_writer.sv
logic/bas_output_stage.sv
logic/fpga_to_cpu.sv
testbench/f2c_asserts.sv
testbench/tb_fpga_to_cpu.sv

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_fpga_to_cpu -f compile.f \
    && ./obj_dir/Vtb_fpga_to_cpu > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation ended with an error"; exit 1; }
cat sim.log
grep -q "CHECKS FAILED" sim.log && exit 1
grep -q "ALL CHECKS PASSED" sim.log || exit 1
exit 0
